/* mrd_pkg.sv */
package mrd_pkg;

	// ------------------------------------------------------------------
	// memory geometry
	// ------------------------------------------------------------------

	// modulo-7 interleave, fixed by the address mapping
	localparam int n_banks = 7;
	localparam int w_addr = 12;
	// row inside one bank
	localparam int w_row = 9;
	// radix 2..5, so at most five lanes
	localparam int max_radix = 5;
	localparam int w_sample = 18;
	// lane index that selects no bank
	localparam logic [2:0] bank_none = 3'd7;

	// ------------------------------------------------------------------
	// data types
	// ------------------------------------------------------------------

	typedef struct packed
	{
		logic signed [w_sample-1:0] re;
		logic signed [w_sample-1:0] im;
	} cplx_t;

	typedef struct packed
	{
		logic [2:0] radix;
		logic [w_addr-1:0] stride;
		logic [w_addr-1:0] base;
		logic [w_addr-1:0] bfly_count;
	} stage_cmd_t;

	// one read request per bank
	typedef struct packed
	{
		logic rden;
		logic [w_row-1:0] row;
	} bank_req_t;

	typedef struct packed
	{
		logic valid;
		logic [2:0] radix;
		cplx_t [max_radix-1:0] lane;
	} bfly_out_t;

	typedef enum logic [1:0]
	{
		rd_idle,
		rd_run,
		rd_drain
	} rd_state_e;

	typedef struct packed
	{
		logic wren;
		logic [w_addr-1:0] addr;
		cplx_t data;
	} wr_req_t;

endpackage

/* mrd_div7.sv */
module mrd_div7
(
	input  logic [mrd_pkg::w_addr-1:0] addr,
	output logic [2:0] bank,
	output logic [mrd_pkg::w_row-1:0] row
);

	// 585/4096 sits just under 1/7
	// so the estimate is exact or one short
	logic [mrd_pkg::w_addr+9:0] prod;
	logic [9:0] q_est;
	logic [mrd_pkg::w_addr-1:0] r_est;

	assign prod = addr * 10'd585;
	assign q_est = prod[mrd_pkg::w_addr+9:mrd_pkg::w_addr];

	// remainder of the estimate, 0..13
	assign r_est = addr - mrd_pkg::w_addr'(q_est * 4'd7);

	// correction step
	always_comb
	begin
		if (r_est >= mrd_pkg::w_addr'(7))
		begin
			bank = 3'(r_est - mrd_pkg::w_addr'(7));
			row = mrd_pkg::w_row'(q_est + 10'd1);
		end
		else
		begin
			bank = r_est[2:0];
			row = q_est[mrd_pkg::w_row-1:0];
		end
	end

endmodule

/* mrd_bfly_addr_gen.sv */
module mrd_bfly_addr_gen
(
	input  logic clk,
	input  logic rst_n,
	input  logic issue,
	input  mrd_pkg::stage_cmd_t stage,
	input  logic stage_load,
	output logic [mrd_pkg::max_radix-1:0][mrd_pkg::w_addr-1:0] lane_addr,
	output logic [mrd_pkg::max_radix-1:0] lane_valid
);

	logic loaded;
	logic [mrd_pkg::w_addr-1:0] bfly_cnt;

	// stage parameters, held for the whole stage
	logic [mrd_pkg::w_addr-1:0] base_q;
	logic [mrd_pkg::w_addr-1:0] stride_q;
	logic [2:0] radix_q;

	// first sample of the current butterfly
	logic [mrd_pkg::w_addr-1:0] start;

	// consecutive butterflies start at consecutive bases
	assign start = base_q + bfly_cnt;

	// ------------------------------------------------------------------
	// control: stage flag, butterfly counter, lane valids
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			loaded <= 1'b0;
			bfly_cnt <= '0;
			lane_valid <= '0;
		end
		else
		begin
			if (stage_load)
			begin
				loaded <= 1'b1;
				bfly_cnt <= '0;
			end
			else if (issue)
				bfly_cnt <= bfly_cnt + 1'b1;

			// lanes at or above the radix stay quiet
			for (int k = 0; k < mrd_pkg::max_radix; k++)
				lane_valid[k] <= issue && (3'(k) < radix_q);
		end
	end

	// ------------------------------------------------------------------
	// payload: stage latch and lane addresses
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (stage_load)
		begin
			base_q <= stage.base;
			stride_q <= stage.stride;
			radix_q <= stage.radix;
		end

		// lane k reads start + k*stride
		if (issue)
		begin
			for (int k = 0; k < mrd_pkg::max_radix; k++)
				lane_addr[k] <= start + mrd_pkg::w_addr'(k) * stride_q;
		end
	end

	// controller only issues inside a loaded stage
	a_issue_loaded: assert property (@(posedge clk) disable iff (!rst_n)
		issue |-> loaded);

endmodule

/* mrd_bank_mem.sv */
module mrd_bank_mem #(
	parameter int DEPTH = 512
)
(
	input  logic clk,
	input  mrd_pkg::wr_req_t wr,
	input  mrd_pkg::bank_req_t [mrd_pkg::n_banks-1:0] bank_req,
	output mrd_pkg::cplx_t [mrd_pkg::n_banks-1:0] bank_dout
);

	// write side decode
	logic [2:0] wr_bank;
	logic [mrd_pkg::w_row-1:0] wr_row;

	mrd_div7 u_wr_div7
	(
		.addr (wr.addr),
		.bank (wr_bank),
		.row  (wr_row)
	);

	// ------------------------------------------------------------------
	// one sample array per bank
	// ------------------------------------------------------------------
	for (genvar b = 0; b < mrd_pkg::n_banks; b++)
	begin : g_bank
		mrd_pkg::cplx_t mem [DEPTH];
		mrd_pkg::cplx_t dout_q;

		// write port, only this bank's residue
		always_ff @(posedge clk)
		begin
			if (wr.wren && (wr_bank == 3'(b)))
				mem[wr_row] <= wr.data;
		end

		// read port with registered data
		// same-row collision returns the old word
		always_ff @(posedge clk)
		begin
			if (bank_req[b].rden)
				dout_q <= mem[bank_req[b].row];
		end

		assign bank_dout[b] = dout_q;
	end

endmodule

/* mrd_rd_ctrl.sv */
module mrd_rd_ctrl #(
	parameter int CREDITS = 4
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic stage_start,
	input  mrd_pkg::stage_cmd_t stage,
	input  logic credit_ret,
	output logic issue,
	output logic stage_load,
	input  logic [mrd_pkg::max_radix-1:0][mrd_pkg::w_addr-1:0] lane_addr,
	input  logic [mrd_pkg::max_radix-1:0] lane_valid,
	output mrd_pkg::bank_req_t [mrd_pkg::n_banks-1:0] bank_req,
	input  mrd_pkg::cplx_t [mrd_pkg::n_banks-1:0] bank_dout,
	output mrd_pkg::bfly_out_t bfly,
	output logic busy,
	output logic done
);

	localparam int w_cred = $clog2(CREDITS + 1);

	mrd_pkg::rd_state_e state;
	logic [w_cred-1:0] credit_cnt;
	logic [mrd_pkg::w_addr-1:0] iss_cnt;
	logic [mrd_pkg::w_addr-1:0] bfly_count_q;
	logic [2:0] radix_q;
	logic last_issue;

	// in-flight marks: address, request, ram stages
	logic [2:0] vld_pipe;
	logic [2:0] last_pipe;

	// lane decode
	logic [mrd_pkg::max_radix-1:0][2:0] lane_bank;
	logic [mrd_pkg::max_radix-1:0][2:0] lane_idx;
	logic [mrd_pkg::max_radix-1:0][mrd_pkg::w_row-1:0] lane_row;
	logic bank_clash;

	// bank request stage
	logic [mrd_pkg::n_banks-1:0] req_hit;
	logic [mrd_pkg::n_banks-1:0][mrd_pkg::w_row-1:0] req_row_d;
	logic [mrd_pkg::n_banks-1:0] req_rden;
	logic [mrd_pkg::n_banks-1:0][mrd_pkg::w_row-1:0] req_row;

	// bank index, two cycles behind the request
	logic [mrd_pkg::max_radix-1:0][2:0] idx_s2;
	logic [mrd_pkg::max_radix-1:0][2:0] idx_s3;

	// output register
	logic out_vld;
	logic [2:0] out_radix;
	mrd_pkg::cplx_t [mrd_pkg::max_radix-1:0] out_lane;

	// ------------------------------------------------------------------
	// state machine and credits
	// ------------------------------------------------------------------
	assign stage_load = stage_start && (state == mrd_pkg::rd_idle);
	assign busy = (state != mrd_pkg::rd_idle);
	// no credit, no issue
	assign issue = (state == mrd_pkg::rd_run) && (credit_cnt != '0);
	assign last_issue = issue && (iss_cnt == bfly_count_q - 1'b1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= mrd_pkg::rd_idle;
			iss_cnt <= '0;
			credit_cnt <= w_cred'(CREDITS);
		end
		else
		begin
			case (state)
				mrd_pkg::rd_idle:
				begin
					iss_cnt <= '0;
					if (stage_load)
						state <= mrd_pkg::rd_run;
				end
				mrd_pkg::rd_run:
				begin
					if (issue)
						iss_cnt <= iss_cnt + 1'b1;
					if (last_issue)
						state <= mrd_pkg::rd_drain;
				end
				// wait for the last butterfly to leave
				mrd_pkg::rd_drain:
				begin
					if (done)
						state <= mrd_pkg::rd_idle;
				end
				default:
					state <= mrd_pkg::rd_idle;
			endcase

			case ({issue, credit_ret})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// stage values needed here
	always_ff @(posedge clk)
	begin
		if (stage_load)
		begin
			bfly_count_q <= stage.bfly_count;
			radix_q <= stage.radix;
		end
	end

	// ------------------------------------------------------------------
	// lane decode and bank routing
	// ------------------------------------------------------------------
	for (genvar k = 0; k < mrd_pkg::max_radix; k++)
	begin : g_lane
		mrd_div7 u_div7
		(
			.addr (lane_addr[k]),
			.bank (lane_bank[k]),
			.row  (lane_row[k])
		);

		// invalid lanes point nowhere
		assign lane_idx[k] = lane_valid[k] ? lane_bank[k] : mrd_pkg::bank_none;
	end

	// each bank picks the lane pointing at it, lowest lane first
	always_comb
	begin
		for (int b = 0; b < mrd_pkg::n_banks; b++)
		begin
			req_hit[b] = 1'b0;
			req_row_d[b] = '0;
			for (int k = mrd_pkg::max_radix - 1; k >= 0; k--)
			begin
				if (lane_idx[k] == 3'(b))
				begin
					req_hit[b] = 1'b1;
					req_row_d[b] = lane_row[k];
				end
			end
		end
	end

	// pairwise check of valid lane banks
	always_comb
	begin
		bank_clash = 1'b0;
		for (int i = 0; i < mrd_pkg::max_radix; i++)
			for (int j = i + 1; j < mrd_pkg::max_radix; j++)
				if (lane_valid[i] && lane_valid[j] && (lane_bank[i] == lane_bank[j]))
					bank_clash = 1'b1;
	end

	always_comb
	begin
		for (int b = 0; b < mrd_pkg::n_banks; b++)
			bank_req[b] = '{rden: req_rden[b], row: req_row[b]};
	end

	// ------------------------------------------------------------------
	// delay line and output stage
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			req_rden <= '0;
			vld_pipe <= '0;
			last_pipe <= '0;
			out_vld <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			req_rden <= req_hit;
			vld_pipe <= {vld_pipe[1:0], issue};
			last_pipe <= {last_pipe[1:0], last_issue};
			out_vld <= vld_pipe[2];
			// done rides with the last valid
			done <= vld_pipe[2] && last_pipe[2];
		end
	end

	always_ff @(posedge clk)
	begin
		req_row <= req_row_d;
		idx_s2 <= lane_idx;
		idx_s3 <= idx_s2;
		out_radix <= radix_q;
		// steer bank data into lanes
		for (int k = 0; k < mrd_pkg::max_radix; k++)
		begin
			if (idx_s3[k] == mrd_pkg::bank_none)
				out_lane[k] <= '0;
			else
				out_lane[k] <= bank_dout[idx_s3[k]];
		end
	end

	assign bfly = '{valid: out_vld, radix: out_radix, lane: out_lane};

	// address generator output must map conflict-free
	a_no_bank_clash: assert property (@(posedge clk) disable iff (!rst_n)
		!bank_clash);

	// downstream never returns more than it got
	a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
		credit_cnt <= w_cred'(CREDITS));

endmodule

/* mrd_top.sv */
module mrd_top #(
	parameter int CREDITS = 4,
	parameter int DEPTH = 512
)
(
	input  logic clk,
	input  logic rst_n,
	input  mrd_pkg::wr_req_t wr,
	input  logic stage_start,
	input  mrd_pkg::stage_cmd_t stage,
	input  logic credit_ret,
	output mrd_pkg::bfly_out_t bfly,
	output logic busy,
	output logic done
);

	// controller to address generator
	logic issue;
	logic stage_load;

	// address generator to controller
	logic [mrd_pkg::max_radix-1:0][mrd_pkg::w_addr-1:0] lane_addr;
	logic [mrd_pkg::max_radix-1:0] lane_valid;

	// controller to and from banks
	mrd_pkg::bank_req_t [mrd_pkg::n_banks-1:0] bank_req;
	mrd_pkg::cplx_t [mrd_pkg::n_banks-1:0] bank_dout;

	mrd_bfly_addr_gen u_addr_gen
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.stage      (stage),
		.stage_load (stage_load),
		.lane_addr  (lane_addr),
		.lane_valid (lane_valid)
	);

	mrd_rd_ctrl #(
		.CREDITS (CREDITS)
	) u_rd_ctrl
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.stage_start (stage_start),
		.stage       (stage),
		.credit_ret  (credit_ret),
		.issue       (issue),
		.stage_load  (stage_load),
		.lane_addr   (lane_addr),
		.lane_valid  (lane_valid),
		.bank_req    (bank_req),
		.bank_dout   (bank_dout),
		.bfly        (bfly),
		.busy        (busy),
		.done        (done)
	);

	mrd_bank_mem #(
		.DEPTH (DEPTH)
	) u_bank_mem
	(
		.clk       (clk),
		.wr        (wr),
		.bank_req  (bank_req),
		.bank_dout (bank_dout)
	);

endmodule

/* tb_mrd_top.sv */
module tb_mrd_top;

	// five credits cover the four-cycle read latency plus the return cycle
	localparam int credits = 5;

	typedef mrd_pkg::cplx_t [mrd_pkg::max_radix-1:0] lanes_t;

	logic clk;
	logic rst_n;
	mrd_pkg::wr_req_t wr;
	logic stage_start;
	mrd_pkg::stage_cmd_t stage;
	logic credit_ret;
	mrd_pkg::bfly_out_t bfly;
	logic busy;
	logic done;

	// reference copy of every loaded sample
	mrd_pkg::cplx_t model [0:4095];

	// expected lanes per butterfly, in output order
	lanes_t exp_q[$];
	lanes_t last_exp[$];

	int value_errors;
	int rule_errors;

	mrd_top #(
		.CREDITS (credits),
		.DEPTH   (512)
	) dut_i
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.wr          (wr),
		.stage_start (stage_start),
		.stage       (stage),
		.credit_ret  (credit_ret),
		.bfly        (bfly),
		.busy        (busy),
		.done        (done)
	);

	always #20 clk = ~clk;

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------

	task automatic compare_value(input string name, input logic [35:0] exp,
		input logic [35:0] act);
		assert (act === exp)
		else
		begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_rule(input bit ok, input string msg);
		assert (ok)
		else
		begin
			$display("Error: %s", msg);
			rule_errors++;
		end
	endtask

	// ------------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------------

	// one sample into the banks and the model
	task automatic write_sample(input int addr, input mrd_pkg::cplx_t data);
		@(negedge clk);
		wr = '{wren: 1'b1, addr: mrd_pkg::w_addr'(addr), data: data};
		@(negedge clk);
		wr.wren = 1'b0;
		model[addr] = data;
	endtask

	// E records that follow an S record
	task automatic read_expected(input int fd, input int radix, input int count);
		logic [7:0] code;
		int n;
		int re;
		int im;
		lanes_t lanes;
		exp_q.delete();
		for (int j = 0; j < count; j++)
		begin
			lanes = '0;
			n = $fscanf(fd, " %c", code);
			check_rule(n == 1 && code == "E", "trace is missing an expected-output record");
			// only the lanes below the radix are listed
			for (int k = 0; k < radix; k++)
			begin
				n = $fscanf(fd, "%h %h", re, im);
				lanes[k] = '{re: mrd_pkg::w_sample'(re), im: mrd_pkg::w_sample'(im)};
			end
			exp_q.push_back(lanes);
		end
	endtask

	// start one stage, watch every output cycle, return credits late
	task automatic run_stage(input string name, input mrd_pkg::stage_cmd_t cmd,
		input int cmax);
		int cyc;
		int n_seen;
		int outstanding;
		int last_vld;
		int done_cyc;
		int limit;
		int pick;
		int a;
		bit done_seen;
		bit finished;
		int due_q[$];
		lanes_t exp_l;
		mrd_pkg::stage_cmd_t ignored;
		cyc = 0;
		n_seen = 0;
		outstanding = 0;
		last_vld = 0;
		done_cyc = 0;
		done_seen = 1'b0;
		finished = 1'b0;
		limit = cmd.bfly_count * (cmax + 6) + 40;
		ignored = '{radix: 3'd2, stride: 12'd1, base: 12'h040, bfly_count: 12'd1};

		@(negedge clk);
		stage = cmd;
		stage_start = 1'b1;
		@(negedge clk);
		stage_start = 1'b0;
		check_rule(busy === 1'b1, $sformatf("%s: busy did not rise after stage_start", name));

		while (!finished && cyc < limit)
		begin
			@(negedge clk);
			cyc++;
			credit_ret = 1'b0;

			// a second start while busy has to be dropped
			if (cyc == 2)
			begin
				check_rule(busy === 1'b1, $sformatf("%s: busy low during the stage", name));
				stage = ignored;
				stage_start = 1'b1;
			end
			else if (cyc == 3)
			begin
				stage = cmd;
				stage_start = 1'b0;
			end

			if (bfly.valid === 1'b1)
			begin
				n_seen++;
				// fixed latency from busy, then back to back when credits come straight back
				if (n_seen == 1)
					check_rule(cyc == 4, $sformatf("%s: first butterfly not 4 cycles after busy",
						name));
				else if (cmax == 0)
					check_rule(cyc == last_vld + 1,
						$sformatf("%s: gap between butterflies with full credit return", name));
				last_vld = cyc;
				outstanding++;
				check_rule(outstanding <= credits,
					$sformatf("%s: more butterflies outstanding than credits", name));
				check_rule(!done_seen, $sformatf("%s: butterfly after done", name));
				if (exp_q.size() == 0)
					check_rule(1'b0, $sformatf("%s: extra butterfly, none expected", name));
				else
				begin
					exp_l = exp_q.pop_front();
					compare_value($sformatf("%s bfly%0d radix", name, n_seen - 1),
						36'(cmd.radix), 36'(bfly.radix));
					for (int k = 0; k < cmd.radix; k++)
					begin
						// stride rule straight from the stage command
						a = cmd.base + (n_seen - 1) + k * cmd.stride;
						compare_value($sformatf("%s bfly%0d lane%0d trace", name, n_seen - 1, k),
							exp_l[k], bfly.lane[k]);
						compare_value($sformatf("%s bfly%0d lane%0d model", name, n_seen - 1, k),
							model[a], bfly.lane[k]);
					end
				end
				due_q.push_back(cyc + int'($urandom() % (cmax + 1)));
			end

			if (done === 1'b1)
			begin
				check_rule(bfly.valid === 1'b1 && n_seen == cmd.bfly_count,
					$sformatf("%s: done without the last butterfly", name));
				check_rule(!done_seen, $sformatf("%s: done pulsed twice", name));
				done_seen = 1'b1;
				done_cyc = cyc;
			end
			else if (bfly.valid === 1'b1 && n_seen == cmd.bfly_count)
				check_rule(1'b0, $sformatf("%s: last butterfly came without done", name));

			if (done_seen && cyc == done_cyc + 1)
				check_rule(busy === 1'b0, $sformatf("%s: busy did not fall after done", name));

			// one matured credit per cycle, oldest first
			pick = -1;
			for (int k = 0; k < due_q.size(); k++)
			begin
				if (pick < 0 && due_q[k] <= cyc)
					pick = k;
			end
			if (pick >= 0)
			begin
				due_q.delete(pick);
				credit_ret = 1'b1;
				outstanding--;
			end

			// quiet window after done, all credits home
			finished = done_seen && (cyc >= done_cyc + 6) && (due_q.size() == 0) && !credit_ret;
		end

		credit_ret = 1'b0;
		check_rule(finished, $sformatf("%s: timeout, stage not finished in %0d cycles", name,
			limit));
		compare_value($sformatf("%s bfly count", name), 36'(cmd.bfly_count), 36'(n_seen));
	endtask

	// pull reset while butterflies are in flight
	task automatic reset_mid_stage(input mrd_pkg::stage_cmd_t cmd);
		int cyc;
		cyc = 0;
		@(negedge clk);
		stage = cmd;
		stage_start = 1'b1;
		@(negedge clk);
		stage_start = 1'b0;
		while (bfly.valid !== 1'b1 && cyc < 40)
		begin
			@(negedge clk);
			cyc++;
		end
		check_rule(bfly.valid === 1'b1, "no butterfly came out before the mid-stage reset");
		rst_n = 1'b0;
		for (int k = 0; k < 3; k++)
		begin
			@(negedge clk);
			check_rule(bfly.valid === 1'b0 && busy === 1'b0 && done === 1'b0,
				"valid, busy or done still high during reset");
		end
		rst_n = 1'b1;
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial
	begin
		int fd;
		int n;
		int addr;
		int re;
		int im;
		int radix;
		int stride;
		int base;
		int count;
		int cmax;
		int last_cmax;
		int stage_num;
		bit eof_seen;
		logic [7:0] code;
		logic [8*128-1:0] line;
		mrd_pkg::stage_cmd_t cmd;
		mrd_pkg::stage_cmd_t last_cmd;

		clk = 1'b0;
		rst_n = 1'b0;
		wr = '0;
		stage_start = 1'b0;
		stage = '0;
		credit_ret = 1'b0;
		value_errors = 0;
		rule_errors = 0;
		stage_num = 0;
		last_cmax = 0;
		last_cmd = '0;
		void'($urandom(32'h3d98bf25));

		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		fd = $fopen("mrd_trace.txt", "r");
		if (fd == 0)
			check_rule(1'b0, "cannot open mrd_trace.txt");
		else
		begin
			eof_seen = 1'b0;
			while (!eof_seen)
			begin
				n = $fscanf(fd, " %c", code);
				if (n != 1)
					eof_seen = 1'b1;
				else if (code == "#")
					n = $fgets(line, fd);
				else if (code == "L")
				begin
					n = $fscanf(fd, "%h %h %h", addr, re, im);
					write_sample(addr, '{re: mrd_pkg::w_sample'(re),
						im: mrd_pkg::w_sample'(im)});
				end
				else if (code == "S")
				begin
					n = $fscanf(fd, "%h %h %h %h %h", radix, stride, base, count, cmax);
					cmd = '{radix: 3'(radix), stride: mrd_pkg::w_addr'(stride),
						base: mrd_pkg::w_addr'(base), bfly_count: mrd_pkg::w_addr'(count)};
					read_expected(fd, radix, count);
					last_exp = exp_q;
					last_cmd = cmd;
					last_cmax = cmax;
					stage_num++;
					run_stage($sformatf("stage%0d", stage_num), cmd, cmax);
				end
				else
					check_rule(1'b0, "unknown record in the trace");
			end
			$fclose(fd);
		end

		// last stage again, cut by reset, then in full
		if (stage_num > 0)
		begin
			reset_mid_stage(last_cmd);
			exp_q = last_exp;
			run_stage("reset rerun", last_cmd, last_cmax);
		end

		$display("checks done: %0d value errors, %0d protocol errors", value_errors,
			rule_errors);
		if (value_errors + rule_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* mrd_trace.txt */
# L addr re im | S radix stride base count credit_max | E re im per lane below the radix
# all fields hex, E records follow their S record in output order
L 0 100 3f000
L 1 101 3f001
L 2 102 3f002
L 3 103 3f003
L 4 104 3f004
L 5 105 3f005
L 6 106 3f006
L 7 107 3f007
L 8 108 3f008
L 9 109 3f009
L a 10a 3f00a
L b 10b 3f00b
L 14 114 3f014
L 15 115 3f015
S 5 1 0 8 c
E 100 3f000 101 3f001 102 3f002 103 3f003 104 3f004
E 101 3f001 102 3f002 103 3f003 104 3f004 105 3f005
E 102 3f002 103 3f003 104 3f004 105 3f005 106 3f006
E 103 3f003 104 3f004 105 3f005 106 3f006 107 3f007
E 104 3f004 105 3f005 106 3f006 107 3f007 108 3f008
E 105 3f005 106 3f006 107 3f007 108 3f008 109 3f009
E 106 3f006 107 3f007 108 3f008 109 3f009 10a 3f00a
E 107 3f007 108 3f008 109 3f009 10a 3f00a 10b 3f00b
S 2 3 2 2 1
E 102 3f002 105 3f005
E 103 3f003 106 3f006
S 3 a 0 2 3
E 100 3f000 10a 3f00a 114 3f014
E 101 3f001 10b 3f00b 115 3f015
S 5 1 0 7 0
E 100 3f000 101 3f001 102 3f002 103 3f003 104 3f004
E 101 3f001 102 3f002 103 3f003 104 3f004 105 3f005
E 102 3f002 103 3f003 104 3f004 105 3f005 106 3f006
E 103 3f003 104 3f004 105 3f005 106 3f006 107 3f007
E 104 3f004 105 3f005 106 3f006 107 3f007 108 3f008
E 105 3f005 106 3f006 107 3f007 108 3f008 109 3f009
E 106 3f006 107 3f007 108 3f008 109 3f009 10a 3f00a

/* project.f */
mrd_pkg.sv
mrd_div7.sv
mrd_bfly_addr_gen.sv
mrd_bank_mem.sv
mrd_rd_ctrl.sv
mrd_top.sv
tb_mrd_top.sv

/* Bender.yml */
package:
  name: mrd

sources:
  - mrd_pkg.sv
  - mrd_div7.sv
  - mrd_bfly_addr_gen.sv
  - mrd_bank_mem.sv
  - mrd_rd_ctrl.sv
  - mrd_top.sv
  - target: test
    files:
      - tb_mrd_top.sv
